// ==== source/bp_pkg.sv ====
// shared types for the next-fetch-address stage
//   XLEN          address and data width
//   fetch_info_t  decoded summary of the instruction at fetch_pc
//   prediction_t  one queued branch prediction
//   bp_state_t    control state

package bp_pkg;

	localparam int XLEN = 64; // rv64

	// decoder summary, one per fetch cycle
	typedef struct packed {
		logic is_jal;
		logic is_jalr;
		logic is_branch; // conditional branch
		logic is_call;
		logic is_return;
		logic is_rvc; // compressed, 2 bytes long
		logic [XLEN-1:0] imm; // sign-extended offset
	} fetch_info_t;

	// what was predicted and where to go if that was wrong
	typedef struct packed {
		logic taken;
		logic [XLEN-1:0] alt_pc;
	} prediction_t;

	typedef enum logic [0:0] {
		BOOT, // issue the reset vector once
		RUN
	} bp_state_t;

endpackage

// ==== source/target_gen.sv ====
// static prediction and target arithmetic
//   sequential address, taken target, link address
//   and the prediction record pushed into the resolve queue

module target_gen (
	input bp_pkg::fetch_info_t info,
	input logic [bp_pkg::XLEN-1:0] fetch_pc,
	input logic jalr_valid,
	input logic [bp_pkg::XLEN-1:0] jalr_pc,
	input logic [bp_pkg::XLEN-1:0] stack_top,
	input logic stack_hit,
	output logic predict_taken,
	output logic [bp_pkg::XLEN-1:0] next_pc,
	output logic [bp_pkg::XLEN-1:0] take_pc,
	output bp_pkg::prediction_t record,
	output logic [bp_pkg::XLEN-1:0] link_pc
);

	logic [bp_pkg::XLEN-1:0] step;
	logic [bp_pkg::XLEN-1:0] rel_target; // pc-relative target of jal and branches
	logic [bp_pkg::XLEN-1:0] jalr_target;
	logic backward;

	assign step = bp_pkg::XLEN'(info.is_rvc ? 2 : 4);
	assign next_pc = fetch_pc + step;
	assign rel_target = fetch_pc + info.imm;

	// return address from the stack when it can serve the return,
	// else whatever the register read delivered
	assign jalr_target = stack_hit ? stack_top : jalr_pc;

	assign take_pc = info.is_jalr ? jalr_target : rel_target;

	// backward taken, forward not taken
	assign backward = info.imm[bp_pkg::XLEN-1];
	assign predict_taken = (info.is_branch & backward) | info.is_jal | info.is_jalr;

	// keep the path not chosen, used on a mispredict
	assign record.taken = predict_taken;
	assign record.alt_pc = predict_taken ? next_pc : rel_target;

	assign link_pc = next_pc; // call pushes the address after itself

endmodule

// ==== source/resolve_queue.sv ====
// resolve queue of outstanding branch predictions
//   circular buffer, extra pointer bit separates full from empty
//   flush drops all entries, pop is the branch unit resolve strobe

module resolve_queue #(
	parameter int AW = 4
) (
	input logic CLK,
	input logic reset,
	input logic push,
	input logic pop,
	input logic flush,
	input bp_pkg::prediction_t push_data,
	output bp_pkg::prediction_t head,
	output logic full,
	output logic empty
);

	localparam int DEPTH = 2 ** AW;

	bp_pkg::prediction_t mem [DEPTH];

	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign head = mem[rd_ptr[AW-1:0]]; // oldest unresolved branch

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0; // everything younger than the redirect is gone
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// payload only, pointers say what is live
	always_ff @(posedge CLK) begin
		if (push && !flush) begin
			mem[wr_ptr[AW-1:0]] <= push_data;
		end
	end

	// the control stalls a branch when the queue is full
	assert property (@(posedge CLK) disable iff (reset)
		(push && full) |-> pop);

	// the branch unit only resolves branches that were predicted
	assert property (@(posedge CLK) disable iff (reset)
		pop |-> !empty);

endmodule

// ==== source/return_stack.sv ====
// return address stack
//   ring of entries with a top pointer and a saturating count
//   a push when full overwrites the oldest entry

module return_stack #(
	parameter int AW = 4
) (
	input logic CLK,
	input logic reset,
	input logic push,
	input logic pop,
	input logic flush,
	input logic [bp_pkg::XLEN-1:0] push_addr,
	output logic [bp_pkg::XLEN-1:0] top,
	output logic empty
);

	localparam int DEPTH = 2 ** AW;

	logic [bp_pkg::XLEN-1:0] mem [DEPTH];

	logic [AW-1:0] top_ptr; // slot of the newest entry
	logic [AW:0] count; // live entries, saturates at DEPTH

	assign empty = (count == '0);
	assign top = mem[top_ptr];

	always_ff @(posedge CLK) begin
		if (reset) begin
			top_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			count <= '0; // pointer may stay where it is
		end else if (push && !pop) begin
			top_ptr <= top_ptr + 1'b1; // wraps onto the oldest slot
			if (count != (AW+1)'(DEPTH)) begin
				count <= count + 1'b1;
			end
		end else if (pop && !push) begin
			top_ptr <= top_ptr - 1'b1;
			count <= count - 1'b1;
		end
		// push with pop replaces the top, depth unchanged
	end

	always_ff @(posedge CLK) begin
		if (!flush) begin
			if (push && pop) begin
				mem[top_ptr] <= push_addr;
			end else if (push) begin
				mem[top_ptr + 1'b1] <= push_addr;
			end
		end
	end

	// control only pops when it saw an entry
	assert property (@(posedge CLK) disable iff (reset)
		pop |-> !empty);

endmodule

// ==== source/branch_predict.sv ====
// next fetch address control
//   boot sequence, stall terms and selection priority
//   queue and stack strobes, mispredict detection

module branch_predict #(
	parameter logic [bp_pkg::XLEN-1:0] BOOT_PC = 64'h8000_0000
) (
	input logic CLK,
	input logic reset,
	input bp_pkg::fetch_info_t info,
	input logic fetch_pc_valid,
	input logic [bp_pkg::XLEN-1:0] fetch_pc,
	input logic fetch_ready,
	input logic jalr_valid,
	input logic exception,
	input logic [bp_pkg::XLEN-1:0] exception_pc,
	input logic bru_valid,
	input logic bru_taken,
	input logic predict_taken,
	input logic [bp_pkg::XLEN-1:0] next_pc,
	input logic [bp_pkg::XLEN-1:0] take_pc,
	input bp_pkg::prediction_t head,
	input logic queue_full,
	input logic stack_empty,
	output logic [bp_pkg::XLEN-1:0] fetch_addr,
	output logic fetch_valid,
	output logic mispredict,
	output logic queue_push,
	output logic queue_flush,
	output logic stack_push,
	output logic stack_pop,
	output logic stack_flush,
	output logic stack_hit
);

	bp_pkg::bp_state_t state;

	logic queue_stall;
	logic jalr_stall;
	logic advance;
	logic redirect;
	logic accept; // instruction really leaves the stage this cycle
	logic boot;
	logic fetch_valid_dnxt;
	logic [bp_pkg::XLEN-1:0] fetch_addr_dnxt;

	assign boot = (state == bp_pkg::BOOT);

	// oldest branch resolved against its prediction
	assign mispredict = bru_valid & (bru_taken ^ head.taken);
	assign redirect = mispredict | exception;

	assign queue_stall = info.is_branch & queue_full;
	// a jalr needs either jalr_pc or a return served by the stack
	assign jalr_stall = info.is_jalr & ~jalr_valid & (stack_empty | ~info.is_return);
	assign advance = (fetch_pc_valid | jalr_valid) & fetch_ready & ~queue_stall & ~jalr_stall;

	assign stack_hit = info.is_jalr & info.is_return & ~stack_empty;

	// a redirect discards whatever would have been recorded this cycle
	assign accept = advance & ~boot & ~redirect;

	assign queue_push = accept & info.is_branch;
	assign stack_push = accept & info.is_call & (info.is_jal | info.is_jalr);
	assign stack_pop = accept & stack_hit;
	assign queue_flush = redirect;
	assign stack_flush = redirect;

	always_comb begin
		if (boot) begin
			fetch_addr_dnxt = BOOT_PC;
		end else if (exception) begin
			fetch_addr_dnxt = exception_pc;
		end else if (mispredict) begin
			fetch_addr_dnxt = head.alt_pc; // path the prediction did not take
		end else if (advance) begin
			fetch_addr_dnxt = predict_taken ? take_pc : next_pc;
		end else begin
			fetch_addr_dnxt = fetch_pc; // hold
		end
	end

	assign fetch_valid_dnxt = boot | exception | mispredict | advance;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= bp_pkg::BOOT;
			fetch_addr <= BOOT_PC;
			fetch_valid <= 1'b0;
		end else begin
			state <= bp_pkg::RUN; // boot address goes out once
			fetch_addr <= fetch_addr_dnxt;
			fetch_valid <= fetch_valid_dnxt;
		end
	end

	// nothing is fetched straight out of reset, the boot cycle comes first
	assert property (@(posedge CLK) $past(reset) |-> !fetch_valid);

endmodule

// ==== source/fetch_predict_top.sv ====
// next-fetch-address stage, top level
//   control plus target generation, resolve queue and return stack

module fetch_predict_top #(
	parameter int QUEUE_AW = 4,
	parameter int STACK_AW = 4,
	parameter logic [bp_pkg::XLEN-1:0] BOOT_PC = 64'h8000_0000
) (
	input logic CLK,
	input logic reset,
	input logic fetch_pc_valid,
	input logic [bp_pkg::XLEN-1:0] fetch_pc,
	input bp_pkg::fetch_info_t info,
	input logic fetch_ready,
	input logic jalr_valid,
	input logic [bp_pkg::XLEN-1:0] jalr_pc,
	input logic bru_valid,
	input logic bru_taken,
	input logic exception,
	input logic [bp_pkg::XLEN-1:0] exception_pc,
	output logic [bp_pkg::XLEN-1:0] fetch_addr,
	output logic fetch_valid,
	output logic mispredict
);

	logic predict_taken;
	logic [bp_pkg::XLEN-1:0] next_pc;
	logic [bp_pkg::XLEN-1:0] take_pc;
	logic [bp_pkg::XLEN-1:0] link_pc;
	bp_pkg::prediction_t record;
	bp_pkg::prediction_t head;
	logic queue_push, queue_flush, queue_full;
	logic stack_push, stack_pop, stack_flush, stack_empty, stack_hit;
	logic [bp_pkg::XLEN-1:0] stack_top;

	branch_predict #(.BOOT_PC(BOOT_PC)) ctrl (
		.CLK(CLK), .reset(reset), .info(info),
		.fetch_pc_valid(fetch_pc_valid), .fetch_pc(fetch_pc), .fetch_ready(fetch_ready),
		.jalr_valid(jalr_valid), .exception(exception), .exception_pc(exception_pc),
		.bru_valid(bru_valid), .bru_taken(bru_taken),
		.predict_taken(predict_taken), .next_pc(next_pc), .take_pc(take_pc),
		.head(head), .queue_full(queue_full), .stack_empty(stack_empty),
		.fetch_addr(fetch_addr), .fetch_valid(fetch_valid), .mispredict(mispredict),
		.queue_push(queue_push), .queue_flush(queue_flush),
		.stack_push(stack_push), .stack_pop(stack_pop), .stack_flush(stack_flush),
		.stack_hit(stack_hit)
	);

	target_gen tgen (
		.info(info), .fetch_pc(fetch_pc), .jalr_valid(jalr_valid), .jalr_pc(jalr_pc),
		.stack_top(stack_top), .stack_hit(stack_hit),
		.predict_taken(predict_taken), .next_pc(next_pc), .take_pc(take_pc),
		.record(record), .link_pc(link_pc)
	);

	resolve_queue #(.AW(QUEUE_AW)) bq (
		.CLK(CLK), .reset(reset), .push(queue_push), .pop(bru_valid), // resolve pops
		.flush(queue_flush), .push_data(record),
		.head(head), .full(queue_full), .empty()
	);

	return_stack #(.AW(STACK_AW)) ras (
		.CLK(CLK), .reset(reset), .push(stack_push), .pop(stack_pop),
		.flush(stack_flush), .push_addr(link_pc),
		.top(stack_top), .empty(stack_empty)
	);

endmodule

// ==== test/tb_fetch_predict.sv ====
// testbench for the next-fetch-address stage
//   clock, reset and seeded random stimulus in phases
//   reference model with its own resolve queue and return stack
//   per-cycle checks of fetch_addr, fetch_valid and mispredict, timeout

module tb_fetch_predict;

	localparam logic [bp_pkg::XLEN-1:0] BOOT_PC = 64'h8000_0000;
	localparam int QUEUE_DEPTH = 16;
	localparam int STACK_DEPTH = 16;
	localparam logic [31:0] SEED = 32'h254ea149;

	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES = 4;
	localparam int SEQ_CYCLES = 200;
	localparam int BRANCH_CYCLES = 400;
	localparam int CALL_CYCLES = 400;
	localparam int FULL_CYCLES = 300;
	localparam int MIXED_CYCLES = 500;
	localparam int CYCLE_LIMIT = RESET_CYCLES + IDLE_CYCLES + SEQ_CYCLES + BRANCH_CYCLES
		+ CALL_CYCLES + FULL_CYCLES + MIXED_CYCLES + 100;

	// stimulus phases
	localparam int MODE_IDLE = 0;
	localparam int MODE_SEQ = 1;
	localparam int MODE_BRANCH = 2;
	localparam int MODE_CALL = 3;
	localparam int MODE_FULL = 4;
	localparam int MODE_MIXED = 5;

	logic CLK = 1'b0;
	logic reset;
	logic fetch_pc_valid;
	logic [bp_pkg::XLEN-1:0] fetch_pc;
	bp_pkg::fetch_info_t info;
	logic fetch_ready;
	logic jalr_valid;
	logic [bp_pkg::XLEN-1:0] jalr_pc;
	logic bru_valid;
	logic bru_taken;
	logic exception;
	logic [bp_pkg::XLEN-1:0] exception_pc;
	logic [bp_pkg::XLEN-1:0] fetch_addr;
	logic fetch_valid;
	logic mispredict;

	// reference model state
	bp_pkg::prediction_t mq[$]; // oldest at index 0
	logic [bp_pkg::XLEN-1:0] ms[$]; // newest at the back
	logic m_boot;
	logic stalled; // last instruction did not leave the stage
	logic [bp_pkg::XLEN-1:0] exp_addr;
	logic exp_valid;
	int errors = 0;
	int cycles = 0;

	fetch_predict_top #(
		.QUEUE_AW(4),
		.STACK_AW(4),
		.BOOT_PC(BOOT_PC)
	) UUT (
		.CLK(CLK), .reset(reset), .fetch_pc_valid(fetch_pc_valid), .fetch_pc(fetch_pc),
		.info(info), .fetch_ready(fetch_ready), .jalr_valid(jalr_valid), .jalr_pc(jalr_pc),
		.bru_valid(bru_valid), .bru_taken(bru_taken), .exception(exception),
		.exception_pc(exception_pc), .fetch_addr(fetch_addr), .fetch_valid(fetch_valid),
		.mispredict(mispredict)
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic clear_inputs();
		fetch_pc_valid = 1'b0;
		fetch_pc = '0;
		info = '0;
		fetch_ready = 1'b0;
		jalr_valid = 1'b0;
		jalr_pc = '0;
		bru_valid = 1'b0;
		bru_taken = 1'b0;
		exception = 1'b0;
		exception_pc = '0;
	endtask

	function automatic int resolve_pct(input int mode);
		case (mode)
			MODE_BRANCH: return 30;
			MODE_CALL: return 10;
			MODE_FULL: return 6; // slow resolves so the queue fills up
			MODE_MIXED: return 25;
			default: return 0;
		endcase
	endfunction

	task automatic pick_inputs(input int mode);
		int r;
		logic [bp_pkg::XLEN-1:0] off;
		bp_pkg::fetch_info_t ins;
		if (mode == MODE_IDLE) begin
			clear_inputs();
			return;
		end
		fetch_ready = ($urandom % 8) != 0;
		jalr_valid = ($urandom % 4) == 0;
		jalr_pc = BOOT_PC + 64'(($urandom % 32768) * 2);
		exception = (mode == MODE_MIXED) && (($urandom % 25) == 0);
		exception_pc = 64'h1000 + 64'(($urandom % 256) * 4);
		bru_taken = 1'($urandom % 2);
		bru_valid = (mq.size() != 0) && (($urandom % 100) < resolve_pct(mode));
		if (mode == MODE_FULL && mq.size() != 0 && ($urandom % 8) != 0) begin
			bru_taken = mq[0].taken; // mostly correct so the queue is not flushed
		end
		// a stalled instruction is usually presented again
		if (stalled && ($urandom % 4) != 0) begin
			return;
		end
		ins = '0;
		off = 64'(($urandom % 256) * 2 + 2);
		ins.imm = ($urandom % 2) ? -off : off;
		ins.is_rvc = 1'($urandom % 2);
		r = $urandom % 100;
		case (mode)
			MODE_BRANCH: begin
				ins.is_branch = r < 50;
				ins.is_jal = (r >= 50) && (r < 65);
			end
			MODE_FULL: ins.is_branch = r < 70;
			MODE_CALL: begin
				ins.is_jal = r < 35;
				ins.is_jalr = r >= 35 && r < 75;
				ins.is_call = r < 45;
				ins.is_return = r >= 45 && r < 75;
			end
			MODE_MIXED: begin
				ins.is_branch = r < 30;
				ins.is_jal = r >= 30 && r < 50;
				ins.is_jalr = r >= 50 && r < 80;
				ins.is_call = r >= 40 && r < 58;
				ins.is_return = r >= 58 && r < 75;
			end
			default: ;
		endcase
		info = ins;
		fetch_pc_valid = ($urandom % 10) != 0;
		fetch_pc = BOOT_PC + 64'(($urandom % 32768) * 2);
	endtask

	// one cycle of the reference model, called with the inputs settled
	task automatic model_step();
		logic [bp_pkg::XLEN-1:0] seq_pc;
		logic [bp_pkg::XLEN-1:0] rel_pc;
		logic [bp_pkg::XLEN-1:0] tgt_pc;
		logic taken;
		logic hit;
		logic q_stall;
		logic j_stall;
		logic adv;
		logic mis;
		logic accept;
		bp_pkg::prediction_t rec;
		seq_pc = fetch_pc + (info.is_rvc ? 64'd2 : 64'd4);
		rel_pc = fetch_pc + info.imm;
		taken = (info.is_branch && info.imm[bp_pkg::XLEN-1]) || info.is_jal || info.is_jalr;
		hit = info.is_jalr && info.is_return && (ms.size() != 0);
		tgt_pc = rel_pc;
		if (info.is_jalr) begin
			tgt_pc = hit ? ms[$] : jalr_pc;
		end
		q_stall = info.is_branch && (mq.size() == QUEUE_DEPTH);
		j_stall = info.is_jalr && !jalr_valid && !hit;
		adv = (fetch_pc_valid || jalr_valid) && fetch_ready && !q_stall && !j_stall;
		mis = bru_valid && (mq.size() != 0) && (bru_taken != mq[0].taken);

		if (mispredict !== mis) begin
			errors++;
			$display("Fail mispredict expected %h got %h at cycle %0d", mis, mispredict, cycles);
		end

		exp_valid = m_boot || exception || mis || adv;
		if (m_boot) exp_addr = BOOT_PC;
		else if (exception) exp_addr = exception_pc;
		else if (mis) exp_addr = mq[0].alt_pc;
		else if (adv) exp_addr = taken ? tgt_pc : seq_pc;
		else exp_addr = fetch_pc;

		if (exception || mis) begin
			mq.delete(); // redirect drops everything younger
			ms.delete();
		end else begin
			if (bru_valid && mq.size() != 0) begin
				void'(mq.pop_front());
			end
			accept = adv && !m_boot;
			if (accept && info.is_branch) begin
				rec.taken = taken;
				rec.alt_pc = taken ? seq_pc : rel_pc;
				mq.push_back(rec);
			end
			if (accept && hit) begin
				void'(ms.pop_back());
			end
			if (accept && info.is_call && (info.is_jal || info.is_jalr)) begin
				ms.push_back(seq_pc);
				if (ms.size() > STACK_DEPTH) begin
					void'(ms.pop_front()); // oldest return address is lost
				end
			end
		end
		stalled = !adv && !exception && !mis;
		m_boot = 1'b0;
	endtask

	task automatic check_outputs();
		if (fetch_valid !== exp_valid) begin
			errors++;
			$display("Fail fetch_valid expected %h got %h at cycle %0d",
				exp_valid, fetch_valid, cycles);
		end
		if (fetch_addr !== exp_addr) begin
			errors++;
			$display("Fail fetch_addr expected %h got %h at cycle %0d",
				exp_addr, fetch_addr, cycles);
		end
	endtask

	task automatic run_phase(input int mode, input int n);
		repeat (n) begin
			pick_inputs(mode);
			#1;
			model_step();
			@(posedge CLK);
			#1;
			check_outputs();
		end
	endtask

	initial begin
		void'($urandom(SEED));
		clear_inputs();
		reset = 1'b1;
		m_boot = 1'b1;
		stalled = 1'b0;
		exp_addr = BOOT_PC;
		exp_valid = 1'b0;
		repeat (RESET_CYCLES) begin
			@(posedge CLK);
			#1;
			check_outputs();
		end
		reset = 1'b0;
		run_phase(MODE_IDLE, IDLE_CYCLES); // boot address, then nothing
		run_phase(MODE_SEQ, SEQ_CYCLES);
		run_phase(MODE_BRANCH, BRANCH_CYCLES);
		run_phase(MODE_CALL, CALL_CYCLES);
		run_phase(MODE_FULL, FULL_CYCLES);
		run_phase(MODE_MIXED, MIXED_CYCLES);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
source/bp_pkg.sv
source/target_gen.sv
source/resolve_queue.sv
source/return_stack.sv
source/branch_predict.sv
source/fetch_predict_top.sv
test/tb_fetch_predict.sv

// ==== Makefile ====
# Verilator build and run of the next-fetch-address stage

TOP = tb_fetch_predict

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check run.log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -f compile.f --top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee run.log
	grep -q "TEST PASS" run.log

clean:
	rm -rf obj_dir run.log
